// File: dv/tb_uart_dbg.sv
// Testbench of the UART debug loader; sends host commands on rx_i and checks replies on tx_o
module tb_uart_dbg;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ClksPerBit = 4;
  localparam int unsigned Timeout    = 20000;
  localparam int unsigned QuietClks  = 30 * ClksPerBit;

  // Protocol bytes
  localparam logic [7:0] Ack      = 8'h06;
  localparam logic [7:0] Eot      = 8'h04;
  localparam logic [7:0] CmdRead  = 8'h11;
  localparam logic [7:0] CmdWrite = 8'h12;
  localparam logic [7:0] CmdExec  = 8'h13;

  logic                clk;
  logic                arst_n_i;
  logic                rx_i;
  logic                tx_o;
  uart_dbg_pkg::exec_t exec_o;

  logic [15:0] lfsr;
  logic [7:0]  model_mem [256];
  logic [7:0]  send_q [$];
  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];
  int          value_errs = 0;
  int          other_errs = 0;
  int          exec_cnt = 0;
  logic [15:0] exec_addr;

  uart_dbg_top uut (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .rx_i     ( rx_i     ),
    .tx_o     ( tx_o     ),
    .exec_o   ( exec_o   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Exec pulse monitor
  always @(negedge clk) begin
    if (exec_o.valid) begin
      exec_cnt  <= exec_cnt + 1;
      exec_addr <= exec_o.addr;
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic [15:0] rand_bits(input int unsigned n);
    logic [15:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Serial driver and monitor
  //////////////////////////////////////////////////////////////////////

  // Start, 8 data bits, stop, plus one idle bit
  task automatic send_byte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {2'b11, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      #2;
      rx_i = frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b, output logic ok);
    int unsigned waited;
    waited = 0;
    b      = '0;
    ok     = 1'b0;
    @(negedge clk);
    while (tx_o !== 1'b0 && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < Timeout) else begin
      $display("No start bit on tx_o within %0d cycles", Timeout);
      other_errs++;
    end
    if (waited >= Timeout) return;
    // Move to the middle of the start bit
    repeat (ClksPerBit / 2) @(negedge clk);
    assert (tx_o === 1'b0) else begin
      $display("Start bit on tx_o ended before mid-bit");
      other_errs++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(negedge clk);
      b[i] = tx_o;
    end
    repeat (ClksPerBit) @(negedge clk);
    assert (tx_o === 1'b1) else begin
      $display("Stop bit missing on tx_o");
      other_errs++;
    end
    ok = 1'b1;
  endtask

  // Sends send_q while collecting n_expect reply bytes
  task automatic transfer(input int unsigned n_expect);
    logic [7:0] b;
    logic       ok;
    got_q.delete();
    fork
      begin
        foreach (send_q[i]) send_byte(send_q[i]);
      end
      begin
        for (int unsigned i = 0; i < n_expect; i++) begin
          recv_byte(b, ok);
          if (ok) got_q.push_back(b);
        end
      end
    join
  endtask

  task automatic check_reply(input string name);
    assert (got_q.size() == exp_q.size()) else begin
      $display("Error %s: expected %0d reply bytes, actual %0d", name, exp_q.size(),
               got_q.size());
      value_errs++;
    end
    foreach (exp_q[i]) begin
      if (i < got_q.size()) begin
        assert (got_q[i] === exp_q[i]) else begin
          $display("Error %s byte %0d: expected 0x%02h, actual 0x%02h", name, i, exp_q[i],
                   got_q[i]);
          value_errs++;
        end
      end
    end
  endtask

  // Nothing more may follow a complete reply
  task automatic check_quiet(input string name);
    int unsigned lows;
    lows = 0;
    repeat (QuietClks) begin
      @(negedge clk);
      if (tx_o !== 1'b1) lows++;
    end
    assert (lows == 0) else begin
      $display("Unexpected extra activity on tx_o after %s", name);
      other_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////////////////////////

  task automatic header(input logic [7:0] cmd, input logic [15:0] addr, input logic [15:0] len);
    send_q.delete();
    exp_q.delete();
    send_q.push_back(cmd);
    send_q.push_back(addr[7:0]);
    send_q.push_back(addr[15:8]);
    send_q.push_back(len[7:0]);
    send_q.push_back(len[15:8]);
    exp_q.push_back(Ack);
  endtask

  task automatic write_mem(input string name, input logic [15:0] addr, input logic [15:0] len);
    logic [7:0] d;
    header(CmdWrite, addr, len);
    for (int unsigned i = 0; i < len; i++) begin
      d = 8'(rand_bits(8));
      send_q.push_back(d);
      model_mem[8'(addr + i)] = d;
    end
    exp_q.push_back(Eot);
    transfer(2);
    check_reply(name);
    check_quiet(name);
  endtask

  task automatic read_mem(input string name, input logic [15:0] addr, input logic [15:0] len);
    header(CmdRead, addr, len);
    for (int unsigned i = 0; i < len; i++) begin
      exp_q.push_back(model_mem[8'(addr + i)]);
    end
    exp_q.push_back(Eot);
    transfer(len + 2);
    check_reply(name);
    check_quiet(name);
  endtask

  task automatic exec_test();
    int          base;
    int unsigned waited;
    logic [15:0] addr;
    base   = exec_cnt;
    waited = 0;
    addr   = rand_bits(16);
    send_q.delete();
    exp_q.delete();
    send_q.push_back(CmdExec);
    send_q.push_back(addr[7:0]);
    send_q.push_back(addr[15:8]);
    exp_q.push_back(Ack);
    transfer(1);
    while (exec_cnt == base && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < Timeout) else begin
      $display("No exec pulse seen within %0d cycles", Timeout);
      other_errs++;
    end
    check_reply("exec");
    check_quiet("exec");
    assert (exec_cnt - base == 1) else begin
      $display("Error exec pulses: expected 1, actual %0d", exec_cnt - base);
      value_errs++;
    end
    assert (exec_addr === addr) else begin
      $display("Error exec address: expected 0x%04h, actual 0x%04h", addr, exec_addr);
      value_errs++;
    end
  endtask

  initial begin
    logic [15:0] addr;
    lfsr     = 16'd36194;
    rx_i     = 1'b1;
    arst_n_i = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    arst_n_i = 1'b1;

    // Idle line after reset
    repeat (20) begin
      @(negedge clk);
      assert (tx_o === 1'b1 && exec_o.valid === 1'b0) else begin
        $display("Error reset idle: expected tx_o 1 exec 0, actual tx_o %b exec %b", tx_o,
                 exec_o.valid);
        value_errs++;
      end
    end

    // Lone ACK challenge
    send_q.delete();
    exp_q.delete();
    send_q.push_back(Ack);
    exp_q.push_back(Ack);
    transfer(1);
    check_reply("ack challenge");
    check_quiet("ack challenge");

    // Fill every byte so later reads never see unwritten cells
    write_mem("preload", {8'(rand_bits(8)), 8'h00}, 16'd256);
    repeat (20) write_mem("random write", rand_bits(16), rand_bits(3) + 16'd1);
    repeat (12) read_mem("random read", rand_bits(16), rand_bits(4) + 16'd1);

    addr = {8'(rand_bits(8)), 8'hFA + 8'(rand_bits(2))};
    read_mem("wrap read", addr, 16'd8);
    read_mem("zero length read", rand_bits(16), 16'd0);
    write_mem("zero length write", rand_bits(16), 16'd0);
    exec_test();

    $display("value errors: %0d, other failures: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the UART debug loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
  -f verilog.f --top-module tb_uart_dbg -o sim_uart_dbg
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_uart_dbg > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: verilog.f
verilog/uart_dbg_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mem_bank.sv
verilog/dbg_engine.sv
verilog/uart_dbg_top.sv
dv/tb_uart_dbg.sv

// File: verilog/dbg_engine.sv
// Debug command engine; parses host bytes, accesses the byte banks, raises exec and queues replies
module dbg_engine #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  uart_dbg_pkg::rx_byte_t             rx_i,
  output uart_dbg_pkg::tx_byte_t             tx_o,
  input  logic                               credit_i,
  output uart_dbg_pkg::mem_req_t             mem_req_o,
  output logic [NumBanks-1:0]                mem_en_o,
  input  uart_dbg_pkg::byte_t [NumBanks-1:0] rdata_i,
  output uart_dbg_pkg::exec_t                exec_o
);

  localparam int unsigned BankBits  = $clog2(NumBanks);
  localparam int unsigned FieldBits = 8 * uart_dbg_pkg::AddrBytes;
  localparam int unsigned CntBits   = $clog2(uart_dbg_pkg::AddrBytes);

  typedef enum logic [3:0] {
    IDLE,
    GET_ADDR,
    GET_LEN,
    SEND_ACK,
    READ_MEM,
    SEND_DATA,
    GET_DATA,
    SEND_EOT,
    GET_EXEC
  } state_e;

  state_e                   state_q;
  uart_dbg_pkg::dbg_byte_e  cmd_q;
  logic [CntBits-1:0]       byte_cnt_q;
  logic [1:0]               credit_q;
  uart_dbg_pkg::wire_addr_t addr_q;
  uart_dbg_pkg::wire_addr_t len_q;
  logic [BankBits-1:0]      sel_q;

  logic                     field_last;
  logic                     can_send;
  logic [BankBits-1:0]      bank;
  uart_dbg_pkg::wire_addr_t addr_shift;
  uart_dbg_pkg::wire_addr_t len_shift;

  //////////////////////////////////////////////////////////////////////
  // Field assembly and datapath
  //////////////////////////////////////////////////////////////////////

  assign field_last = byte_cnt_q == CntBits'(uart_dbg_pkg::AddrBytes - 1);
  assign can_send   = credit_q != 2'd0;
  assign bank       = addr_q[BankBits-1:0];

  // Little-endian, so each new byte enters at the top
  assign addr_shift = {rx_i.data, addr_q[FieldBits-1:8]};
  assign len_shift  = {rx_i.data, len_q[FieldBits-1:8]};

  // Exec fires as the last address byte arrives
  assign exec_o.valid = (state_q == GET_EXEC) && rx_i.valid && field_last;
  assign exec_o.addr  = addr_shift;

  always_comb begin
    mem_req_o.we    = state_q == GET_DATA;
    mem_req_o.addr  = addr_q[uart_dbg_pkg::MemAddrBits-1:0] >> BankBits;
    mem_req_o.wdata = rx_i.data;
    mem_en_o        = '0;
    if (state_q == READ_MEM || (state_q == GET_DATA && rx_i.valid)) begin
      mem_en_o[bank] = 1'b1;
    end
  end

  // Replies, each gated by a credit from the transmitter
  always_comb begin
    tx_o.valid = 1'b0;
    tx_o.data  = uart_dbg_pkg::BYTE_ACK;
    case (state_q)
      SEND_ACK: tx_o.valid = can_send;
      SEND_DATA: begin
        tx_o.valid = can_send;
        tx_o.data  = rdata_i[sel_q];
      end
      SEND_EOT: begin
        tx_o.valid = can_send;
        tx_o.data  = uart_dbg_pkg::BYTE_EOT;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    case (state_q)
      GET_ADDR, GET_EXEC: if (rx_i.valid) addr_q <= addr_shift;
      GET_LEN: if (rx_i.valid) len_q <= len_shift;
      READ_MEM: sel_q <= bank;
      SEND_DATA: begin
        if (can_send) begin
          addr_q <= addr_q + 1'b1;
          len_q  <= len_q - 1'b1;
        end
      end
      GET_DATA: begin
        if (rx_i.valid) begin
          addr_q <= addr_q + 1'b1;
          len_q  <= len_q - 1'b1;
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      cmd_q      <= uart_dbg_pkg::BYTE_ACK;
      byte_cnt_q <= '0;
      credit_q   <= 2'd1;
    end else begin
      credit_q <= credit_q + {1'b0, credit_i} - {1'b0, tx_o.valid};
      case (state_q)
        IDLE: begin
          byte_cnt_q <= '0;
          if (rx_i.valid) begin
            cmd_q <= uart_dbg_pkg::dbg_byte_e'(rx_i.data);
            case (rx_i.data)
              uart_dbg_pkg::CMD_READ, uart_dbg_pkg::CMD_WRITE: state_q <= GET_ADDR;
              uart_dbg_pkg::CMD_EXEC: state_q <= GET_EXEC;
              uart_dbg_pkg::BYTE_ACK: state_q <= SEND_ACK;
              // Anything else is noise
              default: ;
            endcase
          end
        end
        GET_ADDR, GET_LEN, GET_EXEC: begin
          if (rx_i.valid) begin
            byte_cnt_q <= field_last ? '0 : byte_cnt_q + 1'b1;
            if (field_last) begin
              state_q <= (state_q == GET_ADDR) ? GET_LEN : SEND_ACK;
            end
          end
        end
        SEND_ACK: begin
          if (can_send) begin
            if (cmd_q == uart_dbg_pkg::CMD_READ) begin
              state_q <= (len_q == '0) ? SEND_EOT : READ_MEM;
            end else if (cmd_q == uart_dbg_pkg::CMD_WRITE) begin
              state_q <= (len_q == '0) ? SEND_EOT : GET_DATA;
            end else begin
              state_q <= IDLE;
            end
          end
        end
        READ_MEM: state_q <= SEND_DATA;
        SEND_DATA: begin
          if (can_send) begin
            state_q <= (len_q == FieldBits'(1)) ? SEND_EOT : READ_MEM;
          end
        end
        GET_DATA: begin
          if (rx_i.valid && len_q == FieldBits'(1)) begin
            state_q <= SEND_EOT;
          end
        end
        SEND_EOT: if (can_send) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: verilog/mem_bank.sv
// One byte-wide bank of the loader memory; write or registered read on enabled cycles
module mem_bank #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                   clk,
  input  logic                   en_i,
  input  uart_dbg_pkg::mem_req_t req_i,
  output uart_dbg_pkg::byte_t    rdata_o
);

  localparam int unsigned Depth     = (1 << uart_dbg_pkg::MemAddrBits) / NumBanks;
  localparam int unsigned LocalBits = uart_dbg_pkg::MemAddrBits - $clog2(NumBanks);

  uart_dbg_pkg::byte_t  mem_q [Depth];
  logic [LocalBits-1:0] local_addr;

  // Upper bits of the broadcast address are zero for this bank
  assign local_addr = req_i.addr[LocalBits-1:0];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (req_i.we) begin
        mem_q[local_addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem_q[local_addr];
      end
    end
  end

endmodule

// File: verilog/uart_dbg_pkg.sv
// Protocol bytes, widths and bus structs of the UART debug loader, referenced by scoped name
package uart_dbg_pkg;

  // Address and length fields on the wire
  localparam int unsigned AddrBytes   = 2;
  // Bits of the address that reach memory
  localparam int unsigned MemAddrBits = 8;

  typedef logic [7:0]             byte_t;
  typedef logic [8*AddrBytes-1:0] wire_addr_t;

  // Byte values of the host protocol
  typedef enum logic [7:0] {
    BYTE_EOT  = 8'h04,
    BYTE_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_byte_e;

  // Receiver to engine
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_byte_t;

  // Engine to transmitter
  typedef struct packed {
    logic  valid;
    byte_t data;
  } tx_byte_t;

  // Broadcast to all banks, addr is already bank-local
  typedef struct packed {
    logic                   we;
    logic [MemAddrBits-1:0] addr;
    byte_t                  wdata;
  } mem_req_t;

  typedef struct packed {
    logic       valid;
    wire_addr_t addr;
  } exec_t;

endpackage

// File: verilog/uart_dbg_top.sv
// Top of the UART debug loader; serial in and out, banked byte memory and the exec output
module uart_dbg_top #(
  parameter int unsigned ClksPerBit = 4,
  parameter int unsigned NumBanks   = 4
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_i,
  output logic                tx_o,
  output uart_dbg_pkg::exec_t exec_o
);

  uart_dbg_pkg::rx_byte_t             rx_byte;
  uart_dbg_pkg::tx_byte_t             tx_byte;
  logic                               tx_credit;
  uart_dbg_pkg::mem_req_t             mem_req;
  logic [NumBanks-1:0]                mem_en;
  uart_dbg_pkg::byte_t [NumBanks-1:0] mem_rdata;

  //////////////////////////////////////////////////////////////////////
  // Serial side
  //////////////////////////////////////////////////////////////////////

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_rx (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .rx_i     ( rx_i     ),
    .byte_o   ( rx_byte  )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_tx (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .byte_i   ( tx_byte   ),
    .credit_o ( tx_credit ),
    .tx_o     ( tx_o      )
  );

  //////////////////////////////////////////////////////////////////////
  // Engine and memory
  //////////////////////////////////////////////////////////////////////

  dbg_engine #(
    .NumBanks ( NumBanks )
  ) i_dbg_engine (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .rx_i      ( rx_byte   ),
    .tx_o      ( tx_byte   ),
    .credit_i  ( tx_credit ),
    .mem_req_o ( mem_req   ),
    .mem_en_o  ( mem_en    ),
    .rdata_i   ( mem_rdata ),
    .exec_o    ( exec_o    )
  );

  // Consecutive addresses land in consecutive banks
  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    mem_bank #(
      .NumBanks ( NumBanks )
    ) i_mem_bank (
      .clk     ( clk          ),
      .en_i    ( mem_en[b]    ),
      .req_i   ( mem_req      ),
      .rdata_o ( mem_rdata[b] )
    );
  end

endmodule

// File: verilog/uart_rx.sv
// Serial receiver, 8N1 with mid-bit sampling; emits one byte pulse per good frame
module uart_rx #(
  parameter int unsigned ClksPerBit = 4
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   rx_i,
  output uart_dbg_pkg::rx_byte_t byte_o
);

  localparam int unsigned CntBits = $clog2(ClksPerBit + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e            state_q;
  logic [2:0]           sync_q;
  logic [CntBits-1:0]   clk_cnt_q;
  logic [2:0]           bit_cnt_q;
  logic                 valid_q;
  uart_dbg_pkg::byte_t  shift_q;

  logic rx_s;
  logic bit_end;
  logic half_bit;

  // Two synchronizer stages, the third flop only feeds edge detection
  assign rx_s     = sync_q[1];
  assign bit_end  = clk_cnt_q == CntBits'(ClksPerBit - 1);
  assign half_bit = clk_cnt_q == CntBits'((ClksPerBit - 1) / 2);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      sync_q    <= '1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[1:0], rx_i};
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (sync_q[2] && !rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (half_bit) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            // Glitch, not a real start bit
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // Framing error drops the byte
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign byte_o.valid = valid_q;
  assign byte_o.data  = shift_q;

endmodule

// File: verilog/uart_tx.sv
// Serial transmitter, 8N1, with a one-byte holding register and a credit back to the sender
module uart_tx #(
  parameter int unsigned ClksPerBit = 4
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  uart_dbg_pkg::tx_byte_t byte_i,
  output logic                   credit_o,
  output logic                   tx_o
);

  localparam int unsigned CntBits = $clog2(ClksPerBit + 1);

  logic [9:0]          shift_q;
  logic                busy_q;
  logic [CntBits-1:0]  clk_cnt_q;
  logic [3:0]          bit_cnt_q;
  logic                hold_vld_q;
  logic                credit_q;
  uart_dbg_pkg::byte_t hold_q;

  logic                bit_end;
  logic                frame_end;
  logic                free;
  logic                load;
  uart_dbg_pkg::byte_t load_data;

  assign bit_end   = clk_cnt_q == CntBits'(ClksPerBit - 1);
  assign frame_end = busy_q && bit_end && (bit_cnt_q == 4'd9);
  assign free      = !busy_q || frame_end;

  // Shifter takes the held byte first, else a new byte goes straight in
  assign load      = free && (hold_vld_q || byte_i.valid);
  assign load_data = hold_vld_q ? hold_q : byte_i.data;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shift_q    <= '1;
      busy_q     <= 1'b0;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      hold_vld_q <= 1'b0;
      credit_q   <= 1'b0;
    end else begin
      credit_q <= load;
      if (load) begin
        // Stop, data, start from MSB down so bit 0 leaves first
        shift_q   <= {1'b1, load_data, 1'b0};
        busy_q    <= 1'b1;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
      end else if (busy_q) begin
        if (bit_end) begin
          clk_cnt_q <= '0;
          bit_cnt_q <= bit_cnt_q + 1'b1;
          shift_q   <= {1'b1, shift_q[9:1]};
          if (bit_cnt_q == 4'd9) begin
            busy_q <= 1'b0;
          end
        end else begin
          clk_cnt_q <= clk_cnt_q + 1'b1;
        end
      end
      if (byte_i.valid && !(load && !hold_vld_q)) begin
        hold_vld_q <= 1'b1;
      end else if (load) begin
        hold_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_i.valid) begin
      hold_q <= byte_i.data;
    end
  end

  assign credit_o = credit_q;
  assign tx_o     = shift_q[0];

endmodule
